/* stamofu_addr_pipeline.f */
common/stamofu_addr_pkg.sv
oc/operand_collector.sv
oc/oc_stage.sv
req/req_addr_gen.sv
req/req_ctrl.sv
rtl/stamofu_addr_pipeline.sv
sim/tb_stamofu_addr_pipeline.sv

/* Makefile */
TOP = tb_stamofu_addr_pipeline

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) \
		-f stamofu_addr_pipeline.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* sim/tb_stamofu_addr_pipeline.sv */
/*
    testbench for the store/AMO/fence address pipeline
    random issue and register-file traffic, requests checked against a model
*/

module tb_stamofu_addr_pipeline import stamofu_addr_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_OPS      = 400;
    localparam int LIMIT_CYCLES = NUM_OPS * 40 + 200;

    logic               CLK;
    logic               nRST;
    logic               issue_valid;
    issue_op_t          issue_op;
    operand_src_t       issue_A;
    operand_src_t       issue_B;
    logic               issue_ready;
    reg_read_t          A_read;
    reg_read_t          B_read;
    prf_read_data_t     reg_read_data;
    prf_fwd_data_t      forward_data;
    logic               REQ_valid;
    req_info_t          REQ;
    logic               REQ_ack;

    // model state
    logic [31:0]                        lcg_state;
    req_info_t                          exp_q [$];
    int                                 issued;
    logic [LOG_STAMOFU_CQ_ENTRIES-1:0]  cq_next;
    logic                               have_pend;
    issue_op_t                          pend_op;
    operand_src_t                       pend_src [2];
    logic [XLEN-1:0]                    pend_val [2];
    logic                               pend_port [2];
    int                                 pend_delay [2];
    operand_src_t                       oc_src [2];
    logic [XLEN-1:0]                    oc_val [2];
    logic                               oc_port [2];
    int                                 oc_wait [2];
    logic                               oc_first;

    stamofu_addr_pipeline i_dut (
        .CLK            (CLK),
        .nRST           (nRST),
        .issue_valid    (issue_valid),
        .issue_op       (issue_op),
        .issue_A        (issue_A),
        .issue_B        (issue_B),
        .issue_ready    (issue_ready),
        .A_read         (A_read),
        .B_read         (B_read),
        .reg_read_data  (reg_read_data),
        .forward_data   (forward_data),
        .REQ_valid      (REQ_valid),
        .REQ            (REQ),
        .REQ_ack        (REQ_ack)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // --------------------
    // random numbers

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // low LCG bits repeat quickly, so words are built from high halves
    function automatic logic [31:0] rand_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_rand();
        lo = next_rand();
        return {hi[31:16], lo[31:16]};
    endfunction

    function automatic int unsigned pick(input int unsigned n);
        logic [31:0] r;
        r = next_rand();
        return {16'd0, r[31:16]} % n;
    endfunction

    // --------------------
    // checks

    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic compare_bit(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_req(input req_info_t got, input req_info_t exp);
        string field;
        field = "";
        if (got.kind !== exp.kind) field = "kind";
        else if (got.op !== exp.op) field = "op";
        else if (got.is_mq !== exp.is_mq) field = "is_mq";
        else if (got.misaligned !== exp.misaligned) field = "misaligned";
        else if (got.misaligned_exception !== exp.misaligned_exception) field = "misaligned_exception";
        else if (got.vpn !== exp.vpn) field = "vpn";
        else if (got.po_word !== exp.po_word) field = "po_word";
        else if (got.byte_mask !== exp.byte_mask) field = "byte_mask";
        else if (got.write_data !== exp.write_data) field = "write_data";
        else if (got.cq_index !== exp.cq_index) field = "cq_index";
        if (field != "") begin
            $display("** Error at %0t: REQ.%s mismatch, got %h expected %h",
                     $time, field, got, exp);
            abort_run();
        end
    endtask

    // --------------------
    // reference model

    // size 0 byte, 1 half, 2 word, 3 AMO or fence
    function automatic logic [3:0] mask_for(input int size, input logic second,
                                            input logic [1:0] ofs);
        logic [15:0] tbl;
        // one nibble per offset, offset 0 in the low nibble
        if (second) begin
            tbl = (size == 2) ? 16'h7310 : 16'h1111;
        end
        else begin
            case (size)
                0:       tbl = 16'h8421;
                1:       tbl = 16'h8C63;
                default: tbl = 16'h8CEF;
            endcase
        end
        return tbl[4*ofs +: 4];
    endfunction

    function automatic void push_expected(input issue_op_t op, input logic [XLEN-1:0] a,
                                          input logic [XLEN-1:0] b);
        logic [XLEN-1:0]    va;
        logic [XLEN-1:0]    nxt;
        logic [2*XLEN-1:0]  rot;
        logic [1:0]         ofs;
        int                 size;
        req_info_t          e;
        if (op.kind == KIND_AMO) va = a;
        else va = a + {{(XLEN-IMM_WIDTH){op.imm12[IMM_WIDTH-1]}}, op.imm12};
        ofs = va[1:0];
        if (op.kind != KIND_STORE) size = 3;
        else if (op.op[OP_SIZE_WORD_BIT]) size = 2;
        else if (op.op[OP_SIZE_HALF_BIT]) size = 1;
        else size = 0;
        rot = {b, b} << (8 * ofs);
        e                      = '0;
        e.kind                 = op.kind;
        e.op                   = op.op;
        e.misaligned           = (size == 2 && ofs != 2'd0) || (size == 1 && ofs == 2'd3);
        e.misaligned_exception = (op.kind == KIND_AMO) && (ofs != 2'd0);
        e.vpn                  = va[XLEN-1:PO_WIDTH];
        e.po_word              = va[PO_WIDTH-1:2];
        e.byte_mask            = mask_for(size, 1'b0, ofs);
        e.write_data           = rot[2*XLEN-1:XLEN];
        e.cq_index             = op.cq_index;
        exp_q.push_back(e);
        // crossing store, second request on the next word
        if (e.misaligned) begin
            nxt         = (va & ~32'h3) + 32'd4;
            e.is_mq     = 1'b1;
            e.vpn       = nxt[XLEN-1:PO_WIDTH];
            e.po_word   = nxt[PO_WIDTH-1:2];
            e.byte_mask = mask_for(size, 1'b1, ofs);
            exp_q.push_back(e);
        end
    endfunction

    // --------------------
    // stimulus

    task automatic make_pending();
        int unsigned r;
        r = pick(8);
        if (r < 5) pend_op.kind = KIND_STORE;
        else if (r < 7) pend_op.kind = KIND_AMO;
        else pend_op.kind = KIND_FENCE;
        pend_op.op       = 4'(pick(16));
        pend_op.imm12    = 12'(rand_word());
        pend_op.cq_index = cq_next;
        cq_next++;
        // 0 zero, 1 forward, else a read ack
        for (int i = 0; i < 2; i++) begin
            r                     = pick(4);
            pend_src[i].is_zero   = (r == 0);
            pend_src[i].forward   = (r == 1);
            pend_port[i]          = (pick(2) == 1);
            pend_delay[i]         = pick(4);
            pend_val[i]           = (r == 0) ? '0 : rand_word();
        end
        // distinct banks keep A and B data apart on the buses
        pend_src[0].bank = 2'(pick(4));
        pend_src[1].bank = pend_src[0].bank + 2'(pick(3) + 1);
        have_pend = 1'b1;
    endtask

    task automatic step_cycle();
        logic           accepted;
        req_info_t      front;
        prf_read_data_t rdd;
        prf_fwd_data_t  fwd;
        reg_read_t      rd [2];
        accepted = issue_valid & issue_ready;
        // request seen in the cycle that just ended
        if (REQ_valid) begin
            if (exp_q.size() == 0) begin
                $display("request at %0t ns with no operation left to expect", $time);
                abort_run();
            end
            else begin
                front = exp_q[0];
                compare_req(REQ, front);
                if (REQ_ack || front.misaligned_exception) begin
                    void'(exp_q.pop_front());
                end
            end
        end
        oc_first = 1'b0;
        if (accepted) begin
            push_expected(pend_op, pend_val[0], pend_val[1]);
            for (int i = 0; i < 2; i++) begin
                oc_src[i]  = pend_src[i];
                oc_val[i]  = pend_val[i];
                oc_port[i] = pend_port[i];
                oc_wait[i] = (pend_src[i].is_zero || pend_src[i].forward) ? -1 : pend_delay[i];
            end
            oc_first  = 1'b1;
            have_pend = 1'b0;
            issued++;
        end
        if (!have_pend && issued < NUM_OPS) begin
            make_pending();
        end
        // register file for the next cycle, noise outside the chosen slots
        for (int bk = 0; bk < PRF_BANK_COUNT; bk++) begin
            fwd[bk] = rand_word();
            for (int pt = 0; pt < PRF_READ_PORTS; pt++) begin
                rdd[bk][pt] = rand_word();
            end
        end
        for (int i = 0; i < 2; i++) begin
            rd[i] = '0;
            if (oc_first && oc_src[i].forward) begin
                fwd[oc_src[i].bank] = oc_val[i];
            end
            if (oc_wait[i] == 0) begin
                rd[i].ack                       = 1'b1;
                rd[i].port                      = oc_port[i];
                rdd[oc_src[i].bank][oc_port[i]] = oc_val[i];
            end
            if (oc_wait[i] >= 0) begin
                oc_wait[i]--;
            end
        end
        issue_valid   <= have_pend && (pick(4) != 0);
        issue_op      <= pend_op;
        issue_A       <= pend_src[0];
        issue_B       <= pend_src[1];
        A_read        <= rd[0];
        B_read        <= rd[1];
        reg_read_data <= rdd;
        forward_data  <= fwd;
        REQ_ack       <= (pick(2) == 1);
    endtask

    // --------------------
    // main sequence

    initial begin
        lcg_state     = 32'h065c23dc;
        nRST          = 1'b0;
        issue_valid   = 1'b0;
        issue_op      = '0;
        issue_A       = '0;
        issue_B       = '0;
        A_read        = '0;
        B_read        = '0;
        reg_read_data = '0;
        forward_data  = '0;
        REQ_ack       = 1'b0;
        issued        = 0;
        cq_next       = '0;
        have_pend     = 1'b0;
        oc_first      = 1'b0;
        oc_wait[0]    = -1;
        oc_wait[1]    = -1;
        repeat (8) @(posedge CLK);
        nRST <= 1'b1;
        @(posedge CLK);
        compare_bit(REQ_valid, 1'b0, "REQ_valid after reset");
        compare_bit(issue_ready, 1'b1, "issue_ready after reset");
        while (issued < NUM_OPS || exp_q.size() != 0) begin
            @(posedge CLK);
            step_cycle();
        end
        // nothing may follow the last expected request
        repeat (10) begin
            @(posedge CLK);
            compare_bit(REQ_valid, 1'b0, "REQ_valid after drain");
        end
        $display("Result: PASSED");
        $finish;
    end

    initial begin
        repeat (LIMIT_CYCLES) @(posedge CLK);
        $display("timeout: requests did not drain within %0d cycles", LIMIT_CYCLES);
        abort_run();
    end

endmodule

/* rtl/stamofu_addr_pipeline.sv */
/*
    store/AMO/fence address pipeline
    operand collection followed by the request stage
*/

module stamofu_addr_pipeline import stamofu_addr_pkg::*; (
    input  logic            CLK,
    input  logic            nRST,

    // issue
    input  logic            issue_valid,
    input  issue_op_t       issue_op,
    input  operand_src_t    issue_A,
    input  operand_src_t    issue_B,
    output logic            issue_ready,

    // register file
    input  reg_read_t       A_read,
    input  reg_read_t       B_read,
    input  prf_read_data_t  reg_read_data,
    input  prf_fwd_data_t   forward_data,

    // request out
    output logic            REQ_valid,
    output req_info_t       REQ,
    input  logic            REQ_ack
);

    logic               launch;
    issue_op_t          launch_op;
    logic [XLEN-1:0]    launch_A;
    logic [XLEN-1:0]    launch_B;
    logic               stall;
    logic               second_half;
    logic               misaligned;
    logic               misaligned_exception;
    req_info_t          addr_info;

    // --------------------
    // stages

    oc_stage u_oc (
        .CLK            (CLK),
        .nRST           (nRST),
        .issue_valid    (issue_valid),
        .issue_op       (issue_op),
        .issue_A        (issue_A),
        .issue_B        (issue_B),
        .A_read         (A_read),
        .B_read         (B_read),
        .reg_read_data  (reg_read_data),
        .forward_data   (forward_data),
        .stall          (stall),
        .issue_ready    (issue_ready),
        .launch         (launch),
        .launch_op      (launch_op),
        .launch_A       (launch_A),
        .launch_B       (launch_B)
    );

    req_addr_gen u_addr (
        .CLK                    (CLK),
        .nRST                   (nRST),
        .launch                 (launch),
        .launch_op              (launch_op),
        .launch_A               (launch_A),
        .launch_B               (launch_B),
        .stall                  (stall),
        .second_half            (second_half),
        .misaligned             (misaligned),
        .misaligned_exception   (misaligned_exception),
        .info                   (addr_info)
    );

    req_ctrl u_ctrl (
        .CLK                    (CLK),
        .nRST                   (nRST),
        .launch                 (launch),
        .misaligned             (misaligned),
        .misaligned_exception   (misaligned_exception),
        .REQ_ack                (REQ_ack),
        .REQ_valid              (REQ_valid),
        .second_half            (second_half),
        .stall                  (stall)
    );

    // --------------------
    // request out, second half is the mq request

    assign REQ.kind                 = addr_info.kind;
    assign REQ.op                   = addr_info.op;
    assign REQ.is_mq                = second_half;
    assign REQ.misaligned           = addr_info.misaligned;
    assign REQ.misaligned_exception = addr_info.misaligned_exception;
    assign REQ.vpn                  = addr_info.vpn;
    assign REQ.po_word              = addr_info.po_word;
    assign REQ.byte_mask            = addr_info.byte_mask;
    assign REQ.write_data           = addr_info.write_data;
    assign REQ.cq_index             = addr_info.cq_index;

endmodule

/* req/req_ctrl.sv */
/*
    request stage controller
    FSM for request valid, the split second half and back-pressure
*/

module req_ctrl (
    input  logic    CLK,
    input  logic    nRST,
    input  logic    launch,
    input  logic    misaligned,
    input  logic    misaligned_exception,
    input  logic    REQ_ack,
    output logic    REQ_valid,
    output logic    second_half,
    output logic    stall
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACTIVE,
        ST_SPLIT
    } req_state_t;

    req_state_t state;
    req_state_t state_next;
    req_state_t retire_state;

    // a freshly launched op lands in active
    assign retire_state = launch ? ST_ACTIVE : ST_IDLE;

    always_comb begin
        REQ_valid   = 1'b0;
        second_half = 1'b0;
        stall       = 1'b0;
        state_next  = state;
        case (state)
            ST_ACTIVE: begin
                REQ_valid = 1'b1;
                if (misaligned_exception) begin
                    // single cycle, no ack needed
                    state_next = retire_state;
                end
                else if (REQ_ack && misaligned) begin
                    stall      = 1'b1;
                    state_next = ST_SPLIT;
                end
                else if (REQ_ack) begin
                    state_next = retire_state;
                end
                else begin
                    stall = 1'b1;
                end
            end
            ST_SPLIT: begin
                REQ_valid   = 1'b1;
                second_half = 1'b1;
                if (REQ_ack) begin
                    state_next = retire_state;
                end
                else begin
                    stall = 1'b1;
                end
            end
            default: begin
                state_next = retire_state;
            end
        endcase
    end

    always_ff @(posedge CLK) begin
        if (!nRST) begin
            state <= ST_IDLE;
        end
        else begin
            state <= state_next;
        end
    end

endmodule

/* req/req_addr_gen.sv */
/*
    request stage datapath
    forms the virtual address, byte mask and lane-rotated store data
*/

module req_addr_gen import stamofu_addr_pkg::*; (
    input  logic            CLK,
    input  logic            nRST,
    input  logic            launch,
    input  issue_op_t       launch_op,
    input  logic [XLEN-1:0] launch_A,
    input  logic [XLEN-1:0] launch_B,
    input  logic            stall,
    input  logic            second_half,
    output logic            misaligned,
    output logic            misaligned_exception,
    output req_info_t       info
);

    stamofu_kind_t                      kind_q;
    logic [3:0]                         op_q;
    logic [IMM_WIDTH-1:0]               imm_q;
    logic [LOG_STAMOFU_CQ_ENTRIES-1:0]  cq_q;
    logic [XLEN-1:0]                    a_q;
    logic [XLEN-1:0]                    b_q;

    logic               is_store;
    logic               is_amo;
    logic [XLEN-1:0]    va;
    logic [XLEN-3:0]    word_next;
    logic [XLEN-1:0]    addr;
    logic [1:0]         ofs;
    logic [3:0]         byte_mask;
    logic [XLEN-1:0]    write_data;

    // --------------------
    // REQ registers

    // kind comes up as fence so no flag is raised out of reset
    always_ff @(posedge CLK) begin
        if (!nRST) begin
            kind_q <= KIND_FENCE;
        end
        else if (launch && !stall) begin
            kind_q <= launch_op.kind;
        end
    end

    always_ff @(posedge CLK) begin
        if (launch && !stall) begin
            op_q  <= launch_op.op;
            imm_q <= launch_op.imm12;
            cq_q  <= launch_op.cq_index;
            a_q   <= launch_A;
            b_q   <= launch_B;
        end
    end

    // --------------------
    // address

    assign is_store = (kind_q == KIND_STORE);
    assign is_amo   = (kind_q == KIND_AMO);

    // AMO addresses are A alone
    assign va = is_amo ? a_q : a_q + {{(XLEN-IMM_WIDTH){imm_q[IMM_WIDTH-1]}}, imm_q};
    assign ofs       = va[1:0];
    assign word_next = va[XLEN-1:2] + 1'b1;
    assign addr      = second_half ? {word_next, 2'b00} : va;

    // mask and misalignment by store size
    always_comb begin
        misaligned = 1'b0;
        byte_mask  = 4'b1111 << ofs;
        if (is_store) begin
            if (op_q[OP_SIZE_WORD_BIT]) begin
                misaligned = (ofs != 2'b00);
                if (second_half) begin
                    byte_mask = ~(4'b1111 << ofs);
                end
            end
            else if (op_q[OP_SIZE_HALF_BIT]) begin
                misaligned = (ofs == 2'b11);
                byte_mask  = second_half ? 4'b0001 : 4'b0011 << ofs;
            end
            else begin
                byte_mask = 4'b0001 << ofs;
            end
        end
    end

    assign misaligned_exception = is_amo & (ofs != 2'b00);

    // rotate B left one byte per offset byte
    always_comb begin
        case (ofs)
            2'b00:   write_data = b_q;
            2'b01:   write_data = {b_q[23:0], b_q[31:24]};
            2'b10:   write_data = {b_q[15:0], b_q[31:16]};
            default: write_data = {b_q[7:0], b_q[31:8]};
        endcase
    end

    // --------------------
    // request info

    always_comb begin
        info                      = '0;
        info.kind                 = kind_q;
        info.op                   = op_q;
        info.misaligned           = misaligned;
        info.misaligned_exception = misaligned_exception;
        info.vpn                  = addr[XLEN-1:PO_WIDTH];
        info.po_word              = addr[PO_WIDTH-1:2];
        info.byte_mask            = byte_mask;
        info.write_data           = write_data;
        info.cq_index             = cq_q;
    end

endmodule

/* oc/oc_stage.sv */
/*
    operand collection stage
    holds one issued operation until both operands are in and REQ can take it
*/

module oc_stage import stamofu_addr_pkg::*; (
    input  logic            CLK,
    input  logic            nRST,
    input  logic            issue_valid,
    input  issue_op_t       issue_op,
    input  operand_src_t    issue_A,
    input  operand_src_t    issue_B,
    input  reg_read_t       A_read,
    input  reg_read_t       B_read,
    input  prf_read_data_t  reg_read_data,
    input  prf_fwd_data_t   forward_data,
    input  logic            stall,
    output logic            issue_ready,
    output logic            launch,
    output issue_op_t       launch_op,
    output logic [XLEN-1:0] launch_A,
    output logic [XLEN-1:0] launch_B
);

    logic       valid_oc;
    issue_op_t  op_oc;
    logic       accept;
    logic       A_present;
    logic       B_present;

    // --------------------
    // operand collectors

    operand_collector u_A (
        .CLK            (CLK),
        .nRST           (nRST),
        .load           (accept),
        .src            (issue_A),
        .rd             (A_read),
        .reg_read_data  (reg_read_data),
        .forward_data   (forward_data),
        .value          (launch_A),
        .present        (A_present)
    );

    operand_collector u_B (
        .CLK            (CLK),
        .nRST           (nRST),
        .load           (accept),
        .src            (issue_B),
        .rd             (B_read),
        .reg_read_data  (reg_read_data),
        .forward_data   (forward_data),
        .value          (launch_B),
        .present        (B_present)
    );

    // --------------------
    // launch and issue handshake

    assign launch      = valid_oc & A_present & B_present & ~stall;
    assign issue_ready = ~valid_oc | launch;
    assign accept      = issue_valid & issue_ready;
    assign launch_op   = op_oc;

    always_ff @(posedge CLK) begin
        if (!nRST) begin
            valid_oc <= 1'b0;
        end
        else if (accept) begin
            valid_oc <= 1'b1;
        end
        else if (launch) begin
            valid_oc <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            op_oc <= issue_op;
        end
    end

endmodule

/* oc/operand_collector.sv */
/*
    operand collector for one source operand
    tracks where the value comes from and keeps it once it has arrived
*/

module operand_collector import stamofu_addr_pkg::*; (
    input  logic            CLK,
    input  logic            nRST,
    input  logic            load,
    input  operand_src_t    src,
    input  reg_read_t       rd,
    input  prf_read_data_t  reg_read_data,
    input  prf_fwd_data_t   forward_data,
    output logic [XLEN-1:0] value,
    output logic            present
);

    operand_src_t       src_q;
    logic               first_q;
    logic               saved_q;
    logic [XLEN-1:0]    saved_word;
    logic               arrive;

    // forward only counts in the first OC cycle
    assign arrive  = (first_q & src_q.forward) | rd.ack;
    assign present = src_q.is_zero | saved_q | arrive;

    always_comb begin
        if (src_q.is_zero) begin
            value = '0;
        end
        else if (saved_q) begin
            value = saved_word;
        end
        else if (first_q && src_q.forward) begin
            value = forward_data[src_q.bank];
        end
        else begin
            value = reg_read_data[src_q.bank][rd.port];
        end
    end

    always_ff @(posedge CLK) begin
        if (!nRST) begin
            src_q   <= '0;
            first_q <= 1'b0;
            saved_q <= 1'b0;
        end
        else if (load) begin
            src_q   <= src;
            first_q <= 1'b1;
            saved_q <= 1'b0;
        end
        else begin
            first_q <= 1'b0;
            saved_q <= saved_q | arrive;
        end
    end

    // keep late arrivals for a stalled launch
    always_ff @(posedge CLK) begin
        if (!load && arrive && !saved_q) begin
            saved_word <= value;
        end
    end

endmodule

/* common/stamofu_addr_pkg.sv */
/*
    store/AMO/fence address pipeline shared definitions
    core sizes, operation kind and the packed structs used across the pipeline
*/

package stamofu_addr_pkg;

    // --------------------
    // core sizes

    localparam int XLEN                   = 32;
    localparam int PRF_BANK_COUNT         = 4;
    localparam int LOG_PRF_BANK_COUNT     = $clog2(PRF_BANK_COUNT);
    localparam int PRF_READ_PORTS         = 2;
    localparam int STAMOFU_CQ_ENTRIES     = 8;
    localparam int LOG_STAMOFU_CQ_ENTRIES = $clog2(STAMOFU_CQ_ENTRIES);
    localparam int VPN_WIDTH              = 20;
    localparam int PO_WIDTH               = 12;
    localparam int PO_WORD_WIDTH          = PO_WIDTH - 2;
    localparam int IMM_WIDTH              = 12;

    // store size bits within op
    // word wins over half, neither set is a byte store
    localparam int OP_SIZE_WORD_BIT = 1;
    localparam int OP_SIZE_HALF_BIT = 0;

    // --------------------
    // operation kind

    typedef enum logic [1:0] {
        KIND_STORE,
        KIND_AMO,
        KIND_FENCE
    } stamofu_kind_t;

    // --------------------
    // packed structs

    typedef struct packed {
        stamofu_kind_t                      kind;
        logic [3:0]                         op;
        logic [IMM_WIDTH-1:0]               imm12;
        logic [LOG_STAMOFU_CQ_ENTRIES-1:0]  cq_index;
    } issue_op_t;

    typedef struct packed {
        logic                           is_zero;
        logic                           forward;
        logic [LOG_PRF_BANK_COUNT-1:0]  bank;
    } operand_src_t;

    typedef struct packed {
        logic   ack;
        logic   port;
    } reg_read_t;

    typedef struct packed {
        stamofu_kind_t                      kind;
        logic [3:0]                         op;
        logic                               is_mq;
        logic                               misaligned;
        logic                               misaligned_exception;
        logic [VPN_WIDTH-1:0]               vpn;
        logic [PO_WORD_WIDTH-1:0]           po_word;
        logic [3:0]                         byte_mask;
        logic [XLEN-1:0]                    write_data;
        logic [LOG_STAMOFU_CQ_ENTRIES-1:0]  cq_index;
    } req_info_t;

    // register file buses
    typedef logic [PRF_BANK_COUNT-1:0][PRF_READ_PORTS-1:0][XLEN-1:0] prf_read_data_t;
    typedef logic [PRF_BANK_COUNT-1:0][XLEN-1:0] prf_fwd_data_t;

endpackage
